// File: fft_core_top.f
+incdir+include
logic/fft_pkg.sv
logic/sample_window_loader.sv
logic/pair_product_unit.sv
logic/alternating_product_unit.sv
logic/spectral_mixer.sv
logic/fft_core_top.sv
tb/fft_core_assertions.sv
tb/fft_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fft_core_tb -f fft_core_top.f \
  -Mdir build/obj_dir -o fft_core_sim

./build/obj_dir/fft_core_sim > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q "STATUS: FAIL" build/sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" build/sim.log; then
  echo "Simulation ended without a final status"
  exit 1
fi

// File: tb/fft_core_tb.sv
/*
  Testbench for fft_core_top. A credit-aware source sends whole frames,
  a sink returns one output credit per result unless it is told to hold.
  Expected fields come from a reference model of the mixing arithmetic.
  Random samples and gaps use a 32-bit Galois LFSR with a fixed seed.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_core_tb;

  import fft_pkg::*;

  localparam int TOTAL_FRAMES = 35;  // 1 zero, 3 directed, 20 random, 6 held, 5 gapped
  localparam int CYCLE_LIMIT  = 40 * TOTAL_FRAMES + 200;
  localparam int W            = `FFT_SAMPLE_W;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  sample_t   in_sample;
  logic      in_credit;
  logic      res_valid;
  pair_sum_t res_pair_sum;
  alt_sum_t  res_alt_sum;
  mix_t      res_mix;
  logic      res_credit;

  frame_t      sent_frames[$];  // Frames handed to the DUT in the order sent
  int          samples_sent;
  int          credits_back;    // in_credit pulses seen by the source
  int          results_seen;
  int          owed_credits;    // Results the sink has not paid back yet
  int          cycle_count;
  logic        sink_hold;
  logic [31:0] lfsr_state;

  fft_core_top i_fft_core_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_sample    (in_sample),
    .in_credit    (in_credit),
    .res_valid    (res_valid),
    .res_pair_sum (res_pair_sum),
    .res_alt_sum  (res_alt_sum),
    .res_mix      (res_mix),
    .res_credit   (res_credit)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'hD000_0001;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Expected P, D and mixed byte for one frame
  function automatic void ref_result(input frame_t f, input frame_idx_t idx,
                                     output pair_sum_t p, output alt_sum_t d,
                                     output mix_t m);
    int a;
    int b;
    int psum;
    int dsum;
    psum = 0;
    dsum = 0;
    for (int k = 0; k < `FFT_FRAME_LEN / 2; k++) begin
      a = int'(f[2*k*W +: W]);
      b = int'(f[(2*k+1)*W +: W]);
      psum = psum + a * b;
      if (k % 2 == 1) dsum = dsum - a * b;  // Odd pairs count negative
      else dsum = dsum + a * b;
    end
    p = pair_sum_t'(psum);
    d = alt_sum_t'(dsum);
    m = p[7:0] ^ d[7:0] ^ idx;
  endfunction

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped on the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_pair_sum(input pair_sum_t got, input pair_sum_t exp, input int n);
    if (got !== exp) begin
      report_mismatch($sformatf("result %0d pair_sum is %0d, expected %0d", n, got, exp));
    end
  endtask

  task automatic check_alt_sum(input alt_sum_t got, input alt_sum_t exp, input int n);
    if (got !== exp) begin
      report_mismatch($sformatf("result %0d alt_sum is %0d, expected %0d", n, got, exp));
    end
  endtask

  task automatic check_mix(input mix_t got, input mix_t exp, input int n);
    if (got !== exp) begin
      report_mismatch($sformatf("result %0d mix is 0x%02h, expected 0x%02h", n, got, exp));
    end
  endtask

  task automatic advance();
    @(posedge clk);
    #1;
  endtask

  // Spends one credit, waits while none is left
  task automatic send_sample(input sample_t s);
    while (`FFT_IN_FIFO_DEPTH + credits_back - samples_sent <= 0) begin
      in_valid = 1'b0;
      advance();
    end
    in_valid     = 1'b1;
    in_sample    = s;
    samples_sent = samples_sent + 1;
    advance();
    in_valid = 1'b0;
  endtask

  task automatic send_frame(input frame_t f, input bit gaps);
    logic [31:0] r;
    for (int i = 0; i < `FFT_FRAME_LEN; i++) begin
      if (gaps) begin
        draw_bits(2, r);
        repeat (r[1:0]) advance();  // 0 to 3 idle cycles
      end
      send_sample(f[i*W +: W]);
    end
    sent_frames.push_back(f);
  endtask

  task automatic make_random_frame(output frame_t f);
    logic [31:0] r;
    for (int i = 0; i < `FFT_FRAME_LEN; i++) begin
      draw_bits(W, r);
      f[i*W +: W] = sample_t'(r);
    end
  endtask

  task automatic wait_drain();
    while (results_seen < sent_frames.size() || owed_credits != 0) advance();
  endtask

  always @(negedge clk) begin
    if (rst_n && in_credit) credits_back = credits_back + 1;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      stop_with_failure();
    end
  end

  // Sink decides at negedge, drives res_credit after the next rising edge
  initial begin : sink_model
    logic give;
    res_credit = 1'b0;
    forever begin
      @(negedge clk);
      give = 1'b0;
      if (rst_n && res_valid) owed_credits = owed_credits + 1;
      if (!sink_hold && owed_credits > 0) begin
        give         = 1'b1;
        owed_credits = owed_credits - 1;
      end
      @(posedge clk);
      #1 res_credit = give;
    end
  end

  always @(negedge clk) begin : compare_results
    pair_sum_t exp_p;
    alt_sum_t  exp_d;
    mix_t      exp_m;
    if (rst_n && res_valid) begin
      if (results_seen >= sent_frames.size()) begin
        $display("Result %0d came out with no frame sent for it", results_seen);
        stop_with_failure();
      end else begin
        ref_result(sent_frames[results_seen], frame_idx_t'(results_seen),
                   exp_p, exp_d, exp_m);
        check_pair_sum(res_pair_sum, exp_p, results_seen);
        check_alt_sum(res_alt_sum, exp_d, results_seen);
        check_mix(res_mix, exp_m, results_seen);
        results_seen = results_seen + 1;
      end
    end
  end

  initial begin : run_tests
    frame_t f;
    int     hold_start;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_sample  = '0;
    sink_hold  = 1'b0;
    lfsr_state = 32'h5c52;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    // Quiet core until the first sample, then an all-zero frame
    repeat (5) begin
      @(negedge clk);
      if (in_credit || res_valid) report_mismatch("in_credit or res_valid high while idle");
    end
    advance();
    send_frame('0, 1'b0);

    for (int i = 0; i < `FFT_FRAME_LEN; i++) f[i*W +: W] = sample_t'(i + 1);
    send_frame(f, 1'b0);
    send_frame('1, 1'b0);  // Largest P
    for (int i = 0; i < `FFT_FRAME_LEN; i++) begin
      f[i*W +: W] = ((i / 2) % 2 == 1) ? 8'hFF : 8'h00;  // Most negative D
    end
    send_frame(f, 1'b0);

    repeat (20) begin
      make_random_frame(f);
      send_frame(f, 1'b0);
    end
    wait_drain();

    // Sink holds its credits, the result FIFO fills and the input stalls
    sink_hold  = 1'b1;
    hold_start = results_seen;
    repeat (6) begin
      make_random_frame(f);
      send_frame(f, 1'b0);
    end
    repeat (8) advance();
    repeat (20) begin
      @(negedge clk);
      if (in_credit) report_mismatch("in_credit still pulsing with the result FIFO full");
    end
    advance();
    if (results_seen - hold_start > `FFT_OUT_CREDITS) begin
      report_mismatch($sformatf("%0d results sent without credits returned",
                                results_seen - hold_start));
    end
    // Closing sample of the last held frame waits in the input FIFO
    if (samples_sent - credits_back != 1) begin
      report_mismatch($sformatf("%0d samples left in the input FIFO, expected 1",
                                samples_sent - credits_back));
    end
    sink_hold = 1'b0;
    wait_drain();

    repeat (5) begin
      make_random_frame(f);
      send_frame(f, 1'b1);
    end
    wait_drain();
    repeat (10) advance();

    if (results_seen == sent_frames.size() && results_seen == TOTAL_FRAMES) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("Only %0d of %0d results received", results_seen, TOTAL_FRAMES);
      stop_with_failure();
    end
  end

endmodule

// File: tb/fft_core_assertions.sv
/*
  Credit and FIFO rules for fft_core_top, bound to every instance of it.
  Input FIFO fill and output credits are rebuilt from the port pulses,
  so the checks rely on the handshakes alone and not on internal names.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_core_assertions (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_credit,
  input logic res_valid,
  input logic res_credit
);

  import fft_pkg::*;

  localparam int CNT_W = $clog2(`FFT_IN_FIFO_DEPTH + 1);

  logic [CNT_W-1:0] in_fill;      // Samples waiting in the input FIFO
  credit_cnt_t      out_credits;  // Credits the core may still spend

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_fill <= '0;
    end else begin
      case ({in_valid, in_credit})
        2'b10:   in_fill <= in_fill + 1'b1;
        2'b01:   in_fill <= in_fill - 1'b1;
        default: in_fill <= in_fill;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_credits <= credit_cnt_t'(`FFT_OUT_CREDITS);
    end else begin
      case ({res_credit, res_valid})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

  in_fifo_not_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (in_fill < CNT_W'(`FFT_IN_FIFO_DEPTH)))
    else $error("in_valid raised while the input FIFO is full");

  res_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> (out_credits != '0))
    else $error("res_valid raised with no output credit left");

  // First clock after reset release
  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (!in_credit && !res_valid))
    else $error("in_credit or res_valid high in the first cycle after reset");

endmodule

bind fft_core_top fft_core_assertions i_fft_core_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .res_valid  (res_valid),
  .res_credit (res_credit)
);

// File: logic/fft_core_top.sv
/*
  Frame-based product-sum core. Credit flow control on both sides:
  the source starts with FFT_IN_FIFO_DEPTH credits, the core with
  FFT_OUT_CREDITS. Latency from the last sample of a frame to res_valid
  is at least 4 cycles and grows when output credits run out.
*/
`timescale 1ns/1ps

module fft_core_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  fft_pkg::sample_t   in_sample,
  output logic               in_credit,
  output logic               res_valid,
  output fft_pkg::pair_sum_t res_pair_sum,
  output fft_pkg::alt_sum_t  res_alt_sum,
  output fft_pkg::mix_t      res_mix,
  input  logic               res_credit
);

  import fft_pkg::*;

  logic      frame_valid;
  frame_t    frame_data;
  logic      frame_ready;
  logic      pair_valid;
  pair_sum_t pair_sum;
  logic      alt_valid;
  alt_sum_t  alt_sum;

  sample_window_loader i_sample_window_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_sample   (in_sample),
    .in_credit   (in_credit),
    .frame_ready (frame_ready),
    .frame_valid (frame_valid),
    .frame_data  (frame_data)
  );

  // Both units see the same frame in the same cycle
  pair_product_unit i_pair_product_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_data  (frame_data),
    .pair_valid  (pair_valid),
    .pair_sum    (pair_sum)
  );

  alternating_product_unit i_alternating_product_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_data  (frame_data),
    .alt_valid   (alt_valid),
    .alt_sum     (alt_sum)
  );

  spectral_mixer i_spectral_mixer (
    .clk          (clk),
    .rst_n        (rst_n),
    .pair_valid   (pair_valid),
    .pair_sum     (pair_sum),
    .alt_valid    (alt_valid),
    .alt_sum      (alt_sum),
    .frame_ready  (frame_ready),
    .res_valid    (res_valid),
    .res_pair_sum (res_pair_sum),
    .res_alt_sum  (res_alt_sum),
    .res_mix      (res_mix),
    .res_credit   (res_credit)
  );

endmodule

// File: logic/spectral_mixer.sv
/*
  Joins the two unit sums with the running frame index into one result,
  queues it and sends it to the sink under output credits.
  Mixed byte = P[7:0] ^ D[7:0] ^ frame index, index counts frames from reset.
  Results are written one cycle after the unit valids; res_valid and the
  result fields come straight from the FIFO head.
  frame_ready drops once the FIFO holds FFT_RES_FIFO_DEPTH-1 entries.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module spectral_mixer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pair_valid,
  input  fft_pkg::pair_sum_t pair_sum,
  input  logic               alt_valid,
  input  fft_pkg::alt_sum_t  alt_sum,
  output logic               frame_ready,
  output logic               res_valid,
  output fft_pkg::pair_sum_t res_pair_sum,
  output fft_pkg::alt_sum_t  res_alt_sum,
  output fft_pkg::mix_t      res_mix,
  input  logic               res_credit
);

  import fft_pkg::*;

  localparam int PTR_W = $clog2(`FFT_RES_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FFT_RES_FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] READY_LIMIT = CNT_W'(`FFT_RES_FIFO_DEPTH - 1);

  logic        stage_valid;
  pair_sum_t   stage_pair;
  alt_sum_t    stage_alt;
  mix_t        stage_mix;
  frame_idx_t  frame_idx;
  logic        take;
  logic        send;

  pair_sum_t        pair_mem [`FFT_RES_FIFO_DEPTH];
  alt_sum_t         alt_mem  [`FFT_RES_FIFO_DEPTH];
  mix_t             mix_mem  [`FFT_RES_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] res_count;
  credit_cnt_t      credit_cnt;

  assign take = pair_valid && alt_valid;  // Both units fire together

  // One frame in flight at most, so DEPTH-1 leaves room for it
  assign frame_ready = (res_count < READY_LIMIT);

  assign send         = (res_count != '0) && (credit_cnt != '0);
  assign res_valid    = send;
  assign res_pair_sum = pair_mem[rd_ptr];
  assign res_alt_sum  = alt_mem[rd_ptr];
  assign res_mix      = mix_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
      frame_idx   <= '0;
    end else begin
      stage_valid <= take;
      if (take) frame_idx <= frame_idx + 1'b1;
    end
  end

  // Mix uses the two's complement low byte of D
  always_ff @(posedge clk) begin
    if (take) begin
      stage_pair <= pair_sum;
      stage_alt  <= alt_sum;
      stage_mix  <= pair_sum[7:0] ^ alt_sum[7:0] ^ frame_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_valid) begin
      pair_mem[wr_ptr] <= stage_pair;
      alt_mem[wr_ptr]  <= stage_alt;
      mix_mem[wr_ptr]  <= stage_mix;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      res_count <= '0;
    end else begin
      if (stage_valid) wr_ptr <= wr_ptr + 1'b1;
      if (send)        rd_ptr <= rd_ptr + 1'b1;
      case ({stage_valid, send})
        2'b10:   res_count <= res_count + 1'b1;
        2'b01:   res_count <= res_count - 1'b1;
        default: res_count <= res_count;
      endcase
    end
  end

  // Each sent result spends a credit, each res_credit pulse returns one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= credit_cnt_t'(`FFT_OUT_CREDITS);
    end else begin
      case ({res_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: logic/alternating_product_unit.sv
/*
  DCT-like term. Same neighbour products as the pair unit, but pair k is
  subtracted when k is odd. Signed result, valid one cycle after frame_valid.
  The sum may go negative; it never exceeds the range of alt_sum_t.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module alternating_product_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              frame_valid,
  input  fft_pkg::frame_t   frame_data,
  output logic              alt_valid,
  output fft_pkg::alt_sum_t alt_sum
);

  import fft_pkg::*;

  localparam int PAIRS  = `FFT_FRAME_LEN / 2;
  localparam int W      = `FFT_SAMPLE_W;
  localparam int PROD_W = 2 * `FFT_SAMPLE_W;

  alt_sum_t          sum_next;
  logic [PROD_W-1:0] prod;

  always_comb begin
    sum_next = '0;
    prod     = '0;
    for (int k = 0; k < PAIRS; k++) begin
      prod = frame_data[2*k*W +: W] * frame_data[(2*k+1)*W +: W];
      // Product is unsigned, so the cast zero-extends
      if (k % 2 == 1) begin
        sum_next = sum_next - alt_sum_t'(prod);
      end else begin
        sum_next = sum_next + alt_sum_t'(prod);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alt_valid <= 1'b0;
    end else begin
      alt_valid <= frame_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid) begin
      alt_sum <= sum_next;  // Held until the next frame
    end
  end

endmodule

// File: logic/pair_product_unit.sv
/*
  FFT-like energy term. Multiplies sample 2k by sample 2k+1 for all 8 pairs
  and registers the unsigned sum. Result is valid one cycle after frame_valid.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module pair_product_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_valid,
  input  fft_pkg::frame_t    frame_data,
  output logic               pair_valid,
  output fft_pkg::pair_sum_t pair_sum
);

  import fft_pkg::*;

  localparam int PAIRS  = `FFT_FRAME_LEN / 2;
  localparam int W      = `FFT_SAMPLE_W;
  localparam int PROD_W = 2 * `FFT_SAMPLE_W;

  pair_sum_t         sum_next;
  logic [PROD_W-1:0] prod;

  always_comb begin
    sum_next = '0;
    prod     = '0;
    for (int k = 0; k < PAIRS; k++) begin
      prod     = frame_data[2*k*W +: W] * frame_data[(2*k+1)*W +: W];
      sum_next = sum_next + pair_sum_t'(prod);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= frame_valid;
    end
  end

  // Sum register loads once per frame
  always_ff @(posedge clk) begin
    if (frame_valid) begin
      pair_sum <= sum_next;
    end
  end

endmodule

// File: logic/sample_window_loader.sv
/*
  Input side of the core. Samples arrive under credits into a small FIFO,
  then shift into a 16-sample window. Each pop returns one credit.
  The last sample of a frame is only popped while frame_ready is high,
  so a held frame stalls the FIFO and in turn the source.
  frame_data stays valid only in the frame_valid cycle.
*/
`timescale 1ns/1ps
`include "fft_defines.svh"

module sample_window_loader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  fft_pkg::sample_t in_sample,
  output logic             in_credit,
  input  logic             frame_ready,
  output logic             frame_valid,
  output fft_pkg::frame_t  frame_data
);

  import fft_pkg::*;

  localparam int PTR_W  = $clog2(`FFT_IN_FIFO_DEPTH);
  localparam int CNT_W  = $clog2(`FFT_IN_FIFO_DEPTH + 1);
  localparam int FILL_W = $clog2(`FFT_FRAME_LEN);
  localparam int FRAME_W = `FFT_FRAME_LEN * `FFT_SAMPLE_W;
  localparam logic [FILL_W-1:0] LAST_IDX = FILL_W'(`FFT_FRAME_LEN - 1);

  sample_t           fifo_mem [`FFT_IN_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fifo_count;
  logic [FILL_W-1:0] fill_cnt;
  frame_t            window;
  logic              pop;

  // Hold back the closing sample until the mixer has room
  assign pop = (fifo_count != '0) && (frame_ready || (fill_cnt != LAST_IDX));

  assign in_credit  = pop;  // One credit back per sample taken
  assign frame_data = window;

  // FIFO storage written on every accepted sample
  always_ff @(posedge clk) begin
    if (in_valid) begin
      fifo_mem[wr_ptr] <= in_sample;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop)      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_count <= '0;
    end else begin
      case ({in_valid, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // Newest sample enters at the top, oldest ends up in byte 0
  always_ff @(posedge clk) begin
    if (pop) begin
      window <= {fifo_mem[rd_ptr], window[FRAME_W-1:`FFT_SAMPLE_W]};
    end
  end

  // Frame boundary follows the count of popped samples
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt    <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= pop && (fill_cnt == LAST_IDX);
      if (pop) begin
        fill_cnt <= (fill_cnt == LAST_IDX) ? '0 : fill_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/fft_pkg.sv
/*
  Shared vector types for the product-sum core and its testbench.
  pair_sum_t and alt_sum_t are sized for 8 pairs of 8-bit samples.
  alt_sum_t is two's complement.
*/
`include "fft_defines.svh"

package fft_pkg;

  // One input byte
  typedef logic [`FFT_SAMPLE_W-1:0] sample_t;

  // Whole frame with sample 0 (the oldest) in the lowest byte
  typedef logic [`FFT_FRAME_LEN*`FFT_SAMPLE_W-1:0] frame_t;

  // Unsigned sum of the 8 neighbour products
  typedef logic [18:0] pair_sum_t;

  // Same sum with every odd term negated
  typedef logic signed [19:0] alt_sum_t;

  typedef logic [7:0] mix_t;        // Mixed output byte
  typedef logic [7:0] frame_idx_t;  // Wraps after 256 frames
  typedef logic [2:0] credit_cnt_t; // Output credits held by the core

endpackage

// File: include/fft_defines.svh
/*
  Sizing constants for the frame-based product-sum core.
  Both FIFO depths must be powers of two, since their pointers wrap freely.
  FFT_IN_FIFO_DEPTH is also the number of credits the source owns after reset.
*/
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// Bits per input sample
`define FFT_SAMPLE_W 8

// Even count of samples per frame so that samples pair up
`define FFT_FRAME_LEN 16

// Input sample FIFO with one entry per source credit
`define FFT_IN_FIFO_DEPTH 4

// Result FIFO in front of the output credit logic
`define FFT_RES_FIFO_DEPTH 4

// Credits granted by the sink after reset
`define FFT_OUT_CREDITS 2

`endif
